// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_lcd_top
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+.
lcd_pkg.sv
lcd_init_rom.sv
lcd_pattern_gen.sv
lcd_bus_writer.sv
lcd_sequencer.sv
lcd_top.sv
tb_lcd_top.sv

// ==== lcd_bus_writer.sv ====
`default_nettype none

module lcd_bus_writer import lcd_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  logic      word_valid,
    input  logic      word_rs,
    input  logic      word_two_bytes,
    input  rgb565_t   word_data,
    output logic      word_taken,
    output logic      lcd_wr,
    output logic      lcd_rs,
    output lcd_byte_t lcd_data
);

    // phase[0] low means strobe low, phase[1] selects the high byte
    logic       busy;
    logic [1:0] phase;
    logic [1:0] last_phase;
    logic       idle;

    rgb565_t    data_q;
    logic       rs_q;
    logic       two_q;

    assign last_phase = {two_q, 1'b1};

    // the final high cycle already counts as idle
    assign idle       = !busy || (phase == last_phase);
    assign word_taken = idle && word_valid;

    // ------------------------------
    // strobe phase control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            phase <= '0;
        end else if (word_taken) begin
            busy  <= 1'b1;
            phase <= '0;
        end else if (busy) begin
            if (phase == last_phase) begin
                busy <= 1'b0;
            end else begin
                phase <= phase + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_taken) begin
            data_q <= word_data;
            rs_q   <= word_rs;
            two_q  <= word_two_bytes;
        end
    end

    assign lcd_wr   = !(busy && !phase[0]);
    assign lcd_rs   = rs_q;
    assign lcd_data = phase[1] ? data_q[15:8] : data_q[7:0];

endmodule

`default_nettype wire

// ==== lcd_cfg.svh ====
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// ------------------------------
// panel geometry
// ------------------------------

`define LCD_WIDTH         320
`define LCD_HEIGHT        240

// row drawn as a red line
`define LCD_MARK_ROW      16

// ------------------------------
// power-up sequence
// ------------------------------

`define LCD_RESET_CYCLES  4
`define LCD_INIT_LEN      93

// ------------------------------
// rgb565 colours
// ------------------------------

`define LCD_COLOR_RED     16'hF800
`define LCD_COLOR_GREEN   16'h07E0
`define LCD_COLOR_BLUE    16'h001F

`endif

// ==== lcd_init_rom.sv ====
`default_nettype none

module lcd_init_rom import lcd_pkg::*; (
    input  init_index_t index,
    output logic        entry_rs,
    output lcd_byte_t   entry_byte
);

    // msb is the register-select flag, 0 for a command
    logic [8:0] entry;

    always_comb begin
        case (index)
            7'd0:  entry = {1'b0, cmd_vendor_ef};
            7'd1:  entry = {1'b1, 8'h03};
            7'd2:  entry = {1'b1, 8'h80};
            7'd3:  entry = {1'b1, 8'h02};
            7'd4:  entry = {1'b0, cmd_power_b};
            7'd5:  entry = {1'b1, 8'h00};
            7'd6:  entry = {1'b1, 8'hC1};
            7'd7:  entry = {1'b1, 8'h30};
            7'd8:  entry = {1'b0, cmd_power_seq};
            7'd9:  entry = {1'b1, 8'h64};
            7'd10: entry = {1'b1, 8'h03};
            7'd11: entry = {1'b1, 8'h12};
            7'd12: entry = {1'b1, 8'h81};
            7'd13: entry = {1'b0, cmd_timing_a};
            7'd14: entry = {1'b1, 8'h85};
            7'd15: entry = {1'b1, 8'h00};
            7'd16: entry = {1'b1, 8'h78};
            7'd17: entry = {1'b0, cmd_power_a};
            7'd18: entry = {1'b1, 8'h39};
            7'd19: entry = {1'b1, 8'h2C};
            7'd20: entry = {1'b1, 8'h00};
            7'd21: entry = {1'b1, 8'h34};
            7'd22: entry = {1'b1, 8'h02};
            7'd23: entry = {1'b0, cmd_pump_ratio};
            7'd24: entry = {1'b1, 8'h20};
            7'd25: entry = {1'b0, cmd_timing_b};
            7'd26: entry = {1'b1, 8'h00};
            7'd27: entry = {1'b1, 8'h00};
            7'd28: entry = {1'b0, cmd_power_1};
            7'd29: entry = {1'b1, 8'h23};
            7'd30: entry = {1'b0, cmd_power_2};
            7'd31: entry = {1'b1, 8'h10};
            7'd32: entry = {1'b0, cmd_vcom_1};
            7'd33: entry = {1'b1, 8'h3E};
            7'd34: entry = {1'b1, 8'h28};
            7'd35: entry = {1'b0, cmd_vcom_2};
            7'd36: entry = {1'b1, 8'h86};
            7'd37: entry = {1'b0, cmd_access_ctl};
            7'd38: entry = {1'b1, 8'h48};
            // 16 bits per pixel
            7'd39: entry = {1'b0, cmd_pixel_format};
            7'd40: entry = {1'b1, 8'h55};
            7'd41: entry = {1'b0, cmd_frame_ctl};
            7'd42: entry = {1'b1, 8'h00};
            7'd43: entry = {1'b1, 8'h18};
            7'd44: entry = {1'b0, cmd_disp_func};
            7'd45: entry = {1'b1, 8'h08};
            7'd46: entry = {1'b1, 8'h82};
            7'd47: entry = {1'b1, 8'h27};
            7'd48: entry = {1'b0, cmd_gamma_3g};
            7'd49: entry = {1'b1, 8'h00};
            7'd50: entry = {1'b0, cmd_gamma_set};
            7'd51: entry = {1'b1, 8'h01};
            // positive gamma curve
            7'd52: entry = {1'b0, cmd_pos_gamma};
            7'd53: entry = {1'b1, 8'h0F};
            7'd54: entry = {1'b1, 8'h31};
            7'd55: entry = {1'b1, 8'h2B};
            7'd56: entry = {1'b1, 8'h0C};
            7'd57: entry = {1'b1, 8'h0E};
            7'd58: entry = {1'b1, 8'h08};
            7'd59: entry = {1'b1, 8'h4E};
            7'd60: entry = {1'b1, 8'hF1};
            7'd61: entry = {1'b1, 8'h37};
            7'd62: entry = {1'b1, 8'h07};
            7'd63: entry = {1'b1, 8'h10};
            7'd64: entry = {1'b1, 8'h03};
            7'd65: entry = {1'b1, 8'h0E};
            7'd66: entry = {1'b1, 8'h09};
            7'd67: entry = {1'b1, 8'h00};
            // negative gamma curve
            7'd68: entry = {1'b0, cmd_neg_gamma};
            7'd69: entry = {1'b1, 8'h00};
            7'd70: entry = {1'b1, 8'h0E};
            7'd71: entry = {1'b1, 8'h14};
            7'd72: entry = {1'b1, 8'h03};
            7'd73: entry = {1'b1, 8'h11};
            7'd74: entry = {1'b1, 8'h07};
            7'd75: entry = {1'b1, 8'h31};
            7'd76: entry = {1'b1, 8'hC1};
            7'd77: entry = {1'b1, 8'h48};
            7'd78: entry = {1'b1, 8'h08};
            7'd79: entry = {1'b1, 8'h0F};
            7'd80: entry = {1'b1, 8'h0C};
            7'd81: entry = {1'b1, 8'h31};
            7'd82: entry = {1'b1, 8'h36};
            7'd83: entry = {1'b1, 8'h0F};
            7'd84: entry = {1'b0, cmd_sleep_out};
            7'd85: entry = {1'b0, cmd_display_on};
            7'd86: entry = {1'b0, cmd_access_ctl};
            7'd87: entry = {1'b1, 8'h00};
            7'd88: entry = {1'b0, cmd_column_addr};
            7'd89: entry = {1'b1, 8'h00};
            7'd90: entry = {1'b0, cmd_page_addr};
            7'd91: entry = {1'b1, 8'h00};
            // last entry opens the pixel stream
            7'd92: entry = {1'b0, cmd_memory_write};
            default: entry = '0;
        endcase
    end

    assign entry_rs   = entry[8];
    assign entry_byte = entry[7:0];

endmodule

`default_nettype wire

// ==== lcd_pattern_gen.sv ====
`default_nettype none

`include "lcd_cfg.svh"

module lcd_pattern_gen import lcd_pkg::*; (
    input  wire     clk,
    input  wire     reset,
    input  logic    pixel_advance,
    output rgb565_t pixel_color
);

    coord_t row;
    coord_t column;
    coord_t marker;

    // ------------------------------
    // scan counters, rows fastest
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            row    <= '0;
            column <= '0;
            marker <= '0;
        end else if (pixel_advance) begin
            if (row == coord_t'(`LCD_HEIGHT - 1)) begin
                row <= '0;
                if (column == coord_t'(`LCD_WIDTH - 1)) begin
                    column <= '0;
                    // frame done, move the marker one column
                    if (marker == coord_t'(`LCD_WIDTH - 1)) begin
                        marker <= '0;
                    end else begin
                        marker <= marker + 9'd1;
                    end
                end else begin
                    column <= column + 9'd1;
                end
            end else begin
                row <= row + 9'd1;
            end
        end
    end

    // red line wins over the marker column
    always_comb begin
        if (row == coord_t'(`LCD_MARK_ROW)) begin
            pixel_color = `LCD_COLOR_RED;
        end else if (column == marker) begin
            pixel_color = `LCD_COLOR_GREEN;
        end else begin
            pixel_color = `LCD_COLOR_BLUE;
        end
    end

endmodule

`default_nettype wire

// ==== lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

    typedef logic [7:0]  lcd_byte_t;
    typedef logic [15:0] rgb565_t;
    typedef logic [6:0]  init_index_t;
    typedef logic [8:0]  coord_t;

    typedef enum logic [1:0] {
        seq_reset,
        seq_select,
        seq_init,
        seq_pixels
    } seq_state_e;

    // ------------------------------
    // panel command opcodes
    // ------------------------------
    typedef enum logic [7:0] {
        cmd_sleep_out    = 8'h11,
        cmd_gamma_set    = 8'h26,
        cmd_display_on   = 8'h29,
        cmd_column_addr  = 8'h2A,
        cmd_page_addr    = 8'h2B,
        cmd_memory_write = 8'h2C,
        cmd_access_ctl   = 8'h36,
        cmd_pixel_format = 8'h3A,
        cmd_frame_ctl    = 8'hB1,
        cmd_disp_func    = 8'hB6,
        cmd_power_1      = 8'hC0,
        cmd_power_2      = 8'hC1,
        cmd_vcom_1       = 8'hC5,
        cmd_vcom_2       = 8'hC7,
        cmd_power_a      = 8'hCB,
        cmd_power_b      = 8'hCF,
        cmd_pos_gamma    = 8'hE0,
        cmd_neg_gamma    = 8'hE1,
        // vendor timing and power sequence registers
        cmd_timing_a     = 8'hE8,
        cmd_timing_b     = 8'hEA,
        cmd_power_seq    = 8'hED,
        cmd_vendor_ef    = 8'hEF,
        cmd_gamma_3g     = 8'hF2,
        cmd_pump_ratio   = 8'hF7
    } lcd_cmd_e;

endpackage

`default_nettype wire

// ==== lcd_sequencer.sv ====
`default_nettype none

`include "lcd_cfg.svh"

module lcd_sequencer import lcd_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  logic        word_taken,
    input  rgb565_t     pixel_color,
    output logic        lcd_reset_active,
    output logic        lcd_select,
    output logic        word_valid,
    output logic        word_rs,
    output logic        word_two_bytes,
    output rgb565_t     word_data,
    output logic        pixel_advance
);

    seq_state_e  state;
    logic [7:0]  reset_count;
    init_index_t init_index;
    logic        rom_rs;
    lcd_byte_t   rom_byte;

    lcd_init_rom rom_inst (
        .index      (init_index),
        .entry_rs   (rom_rs),
        .entry_byte (rom_byte)
    );

    // ------------------------------
    // power-up state machine
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= seq_reset;
            reset_count <= '0;
            init_index  <= '0;
        end else begin
            case (state)
                seq_reset: begin
                    if (reset_count == 8'(`LCD_RESET_CYCLES - 1)) begin
                        state <= seq_select;
                    end else begin
                        reset_count <= reset_count + 8'd1;
                    end
                end
                seq_select: begin
                    state <= seq_init;
                end
                seq_init: begin
                    if (word_taken) begin
                        init_index <= init_index + 7'd1;
                        if (init_index == init_index_t'(`LCD_INIT_LEN - 1)) begin
                            state <= seq_pixels;
                        end
                    end
                end
                default: begin
                    // pixels run forever
                end
            endcase
        end
    end

    assign lcd_reset_active = (state == seq_reset);
    assign lcd_select       = (state != seq_reset);

    // word offered to the bus writer
    always_comb begin
        word_valid     = 1'b0;
        word_rs        = 1'b0;
        word_two_bytes = 1'b0;
        word_data      = '0;
        if (state == seq_init) begin
            word_valid = 1'b1;
            word_rs    = rom_rs;
            word_data  = {8'h00, rom_byte};
        end else if (state == seq_pixels) begin
            word_valid     = 1'b1;
            word_rs        = 1'b1;
            word_two_bytes = 1'b1;
            word_data      = pixel_color;
        end
    end

    assign pixel_advance = word_taken && (state == seq_pixels);

endmodule

`default_nettype wire

// ==== lcd_top.sv ====
`default_nettype none

module lcd_top import lcd_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    output lcd_byte_t lcd_data,
    output logic      lcd_rs,
    output logic      lcd_wr,
    output logic      lcd_select,
    output logic      lcd_reset_active
);

    logic    word_valid;
    logic    word_rs;
    logic    word_two_bytes;
    rgb565_t word_data;
    logic    word_taken;
    logic    pixel_advance;
    rgb565_t pixel_color;

    lcd_sequencer sequencer_inst (
        .clk              (clk),
        .reset            (reset),
        .word_taken       (word_taken),
        .pixel_color      (pixel_color),
        .lcd_reset_active (lcd_reset_active),
        .lcd_select       (lcd_select),
        .word_valid       (word_valid),
        .word_rs          (word_rs),
        .word_two_bytes   (word_two_bytes),
        .word_data        (word_data),
        .pixel_advance    (pixel_advance)
    );

    lcd_pattern_gen pattern_inst (
        .clk           (clk),
        .reset         (reset),
        .pixel_advance (pixel_advance),
        .pixel_color   (pixel_color)
    );

    lcd_bus_writer writer_inst (
        .clk            (clk),
        .reset          (reset),
        .word_valid     (word_valid),
        .word_rs        (word_rs),
        .word_two_bytes (word_two_bytes),
        .word_data      (word_data),
        .word_taken     (word_taken),
        .lcd_wr         (lcd_wr),
        .lcd_rs         (lcd_rs),
        .lcd_data       (lcd_data)
    );

endmodule

`default_nettype wire

// ==== tb_lcd_top.sv ====
`default_nettype none

`include "lcd_cfg.svh"

module tb_lcd_top;

    localparam int reset_cycles     = 4;
    localparam int frame_pixels     = `LCD_WIDTH * `LCD_HEIGHT;
    localparam int pixels_to_check  = 2 * frame_pixels;
    localparam int timeout_cycles   = 3 * frame_pixels * 4 + 1000;

    logic       clk;
    logic       reset;
    logic [7:0] lcd_data;
    logic       lcd_rs;
    logic       lcd_wr;
    logic       lcd_select;
    logic       lcd_reset_active;

    int          cycle_count       = 0;
    int          reset_edges       = 0;
    int          active_cycles     = 0;
    int          write_count       = 0;
    int          last_strobe_cycle = 0;
    int          pixel_count       = 0;
    int          sleep_out_pos     = -1;
    int          display_on_pos    = -1;
    logic        select_seen       = 1'b0;
    logic        prev_wr           = 1'b1;
    logic        have_low_byte     = 1'b0;
    logic [7:0]  low_byte;
    logic        stream_done       = 1'b0;

    lcd_top lcd_top_inst (
        .clk              (clk),
        .reset            (reset),
        .lcd_data         (lcd_data),
        .lcd_rs           (lcd_rs),
        .lcd_wr           (lcd_wr),
        .lcd_select       (lcd_select),
        .lcd_reset_active (lcd_reset_active)
    );

    always #2 clk = ~clk;

    // ------------------------------
    // reference model and compare
    // ------------------------------
    function automatic logic [15:0] expected_color(input int column, input int row,
                                                   input int marker);
        if (row == `LCD_MARK_ROW) begin
            return `LCD_COLOR_RED;
        end else if (column == marker) begin
            return `LCD_COLOR_GREEN;
        end else begin
            return `LCD_COLOR_BLUE;
        end
    endfunction

    // opcodes of the ILI9341 command set used during power-up
    function automatic logic is_known_command(input logic [7:0] opcode);
        case (opcode)
            8'h11, 8'h26, 8'h29, 8'h2A, 8'h2B, 8'h2C, 8'h36, 8'h3A,
            8'hB1, 8'hB6, 8'hC0, 8'hC1, 8'hC5, 8'hC7, 8'hCB, 8'hCF,
            8'hE0, 8'hE1, 8'hE8, 8'hEA, 8'hED, 8'hEF, 8'hF2, 8'hF7: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s, got %0h expected %0h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // ------------------------------
    // bus monitor
    // ------------------------------
    task automatic check_reset_outputs();
        // registers hold reset values from the second reset edge on
        if (reset_edges > 0) begin
            check_equal(32'(lcd_wr), 32'd1, "write strobe active during reset");
            check_equal(32'(lcd_reset_active), 32'd1, "panel reset not held during reset");
            check_equal(32'(lcd_select), 32'd0, "panel selected during reset");
        end
        reset_edges = reset_edges + 1;
    endtask

    task automatic check_power_up();
        check_equal(32'(lcd_select), 32'(!lcd_reset_active),
                    "panel select is not the inverse of panel reset");
        if (lcd_reset_active) begin
            check_equal(32'(select_seen), 32'd0, "panel reset asserted again");
            active_cycles = active_cycles + 1;
        end else if (!select_seen) begin
            check_equal(active_cycles, `LCD_RESET_CYCLES, "panel reset length in cycles");
            select_seen = 1'b1;
        end
    endtask

    task automatic record_table_write();
        if (write_count == 0) begin
            check_equal(32'(lcd_rs), 32'd0, "first table write is not a command");
            check_equal(32'(lcd_data), 32'hEF, "first table command");
        end
        if (!lcd_rs) begin
            check_equal(32'(is_known_command(lcd_data)), 32'd1,
                        $sformatf("unknown command at table write %0d", write_count));
            if (lcd_data == 8'h11) begin
                sleep_out_pos = write_count;
            end
            if (lcd_data == 8'h29) begin
                display_on_pos = write_count;
            end
            if (lcd_data == 8'h2C) begin
                check_equal(write_count, `LCD_INIT_LEN - 1, "memory write command position");
            end
        end
        if (write_count == `LCD_INIT_LEN - 1) begin
            check_equal(32'(lcd_rs), 32'd0, "last table write is not a command");
            check_equal(32'(lcd_data), 32'h2C, "last table command");
            check_equal(32'(sleep_out_pos >= 0), 32'd1, "sleep out command missing");
            check_equal(32'(display_on_pos > sleep_out_pos), 32'd1,
                        "display on missing or sent before sleep out");
        end
    endtask

    task automatic check_pixel(input logic [15:0] color);
        int row;
        int column;
        int frame;
        row    = pixel_count % `LCD_HEIGHT;
        column = (pixel_count / `LCD_HEIGHT) % `LCD_WIDTH;
        frame  = pixel_count / frame_pixels;
        // the marker columns are always checked, the rest is sampled
        if (column <= 1 || column == `LCD_WIDTH - 1 || ($urandom % 32'd8) == 32'd0) begin
            check_equal(32'(color), 32'(expected_color(column, row, frame % `LCD_WIDTH)),
                        $sformatf("pixel colour at frame %0d column %0d row %0d",
                                  frame, column, row));
        end
        pixel_count = pixel_count + 1;
        if (pixel_count == pixels_to_check) begin
            stream_done = 1'b1;
        end
    endtask

    task automatic record_pixel_byte();
        check_equal(32'(lcd_rs), 32'd1, "pixel byte sent as a command");
        if (!have_low_byte) begin
            low_byte      = lcd_data;
            have_low_byte = 1'b1;
        end else begin
            have_low_byte = 1'b0;
            check_pixel({lcd_data, low_byte});
        end
    endtask

    task automatic check_strobe();
        if (!lcd_wr) begin
            check_equal(32'(prev_wr), 32'd1, "write strobe low for more than one cycle");
            check_equal(32'(lcd_select), 32'd1, "write strobe before the panel was selected");
            if (write_count >= `LCD_INIT_LEN + 1) begin
                check_equal(cycle_count - last_strobe_cycle, 32'd2,
                            "pixel byte spacing in cycles");
            end
            last_strobe_cycle = cycle_count;
            if (write_count < `LCD_INIT_LEN) begin
                record_table_write();
            end else begin
                record_pixel_byte();
            end
            write_count = write_count + 1;
        end
        prev_wr = lcd_wr;
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (!stream_done && cycle_count > timeout_cycles) begin
            $display("timeout: the pixel stream stalled, %0d pixels seen after %0d cycles",
                     pixel_count, cycle_count);
            $display("** FAIL **");
            $fatal(1);
        end else if (reset) begin
            check_reset_outputs();
        end else if (!stream_done) begin
            check_power_up();
            check_strobe();
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        void'($urandom(32'h43f51bc4));
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        wait (stream_done);
        $display("checked %0d table writes and %0d pixels", `LCD_INIT_LEN, pixel_count);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
